/* Bender.yml */
package:
  name: bch_decoder

sources:
  - files:
      - design/gf_pkg.sv
      - design/bch_pkg.sv
      - design/bch_ifs.sv
      - design/syndrome_calc.sv
      - design/ibm_solver.sv
      - design/chien_search.sv
      - design/error_report.sv
      - design/bch_decoder.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/tb_bch_decoder.sv

/* all.f */
+incdir+include
design/gf_pkg.sv
design/bch_pkg.sv
design/bch_ifs.sv
design/syndrome_calc.sv
design/ibm_solver.sv
design/chien_search.sv
design/error_report.sv
design/bch_decoder.sv
testbench/tb_bch_decoder.sv

/* design/bch_decoder.sv */
`timescale 1ns/1ps

module bch_decoder (
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic              i_bit,
	input  logic              i_valid,
	output logic              o_ready,
	output bch_pkg::bch_pos_t o_loc,
	output logic              o_loc_valid,
	input  logic              i_loc_ready,
	output logic              o_done,
	output bch_pkg::bch_cnt_t o_num_err,
	output logic              o_fail
);

	syndrome_if u_syn_if ();
	locator_if  u_lam_if ();
	roots_if    u_roots_if ();

	// ==================================================
	// syndrome
	// ==================================================
	syndrome_calc u_syndrome_calc (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_bit   (i_bit),
		.i_valid (i_valid),
		.o_ready (o_ready),
		.o_syn   (u_syn_if)     // s1, s3
	);

	// ==================================================
	// ibm
	// ==================================================
	ibm_solver u_ibm_solver (
		.i_clk (i_clk),
		.i_rst (i_rst),
		.i_syn (u_syn_if),
		.o_loc (u_lam_if)       // lam0..lam2, degree
	);

	// ==================================================
	// chien search
	// ==================================================
	chien_search u_chien_search (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_lam   (u_lam_if),
		.o_roots (u_roots_if)   // loc0, loc1, count
	);

	error_report u_error_report (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_loc_ready (i_loc_ready),
		.i_roots     (u_roots_if),
		.o_loc       (o_loc),
		.o_loc_valid (o_loc_valid),
		.o_done      (o_done),
		.o_num_err   (o_num_err),
		.o_fail      (o_fail)
	);

endmodule

/* design/bch_ifs.sv */
`timescale 1ns/1ps

// odd syndromes of one frame
interface syndrome_if;
	import gf_pkg::*;

	gf_elem_t s1;
	gf_elem_t s3;
	logic     valid;
	logic     ready;

	modport src (output s1, s3, valid, input ready);
	modport dst (input s1, s3, valid, output ready);
endinterface

// scaled error locator lam0 + lam1*x + lam2*x^2
interface locator_if;
	import gf_pkg::*;
	import bch_pkg::*;

	gf_elem_t lam0;
	gf_elem_t lam1;
	gf_elem_t lam2;
	bch_cnt_t degree;     // BM length, may be 3
	logic     valid;
	logic     ready;

	modport src (output lam0, lam1, lam2, degree, valid, input ready);
	modport dst (input lam0, lam1, lam2, degree, valid, output ready);
endinterface

// roots found by the chien search
interface roots_if;
	import bch_pkg::*;

	bch_pos_t loc0;       // lower position
	bch_pos_t loc1;
	bch_cnt_t count;
	bch_cnt_t degree;
	logic     valid;
	logic     ready;

	modport src (output loc0, loc1, count, degree, valid, input ready);
	modport dst (input loc0, loc1, count, degree, valid, output ready);
endinterface

/* design/bch_pkg.sv */
package bch_pkg;

	// ==================================================
	// BCH(63,51), t = 2
	// ==================================================
	localparam int BCH_N = 63;
	localparam int BCH_K = 51;
	localparam int BCH_T = 2;

	// bit position inside a codeword, 0..62
	typedef logic [$clog2(BCH_N)-1:0] bch_pos_t;

	// error or root count, wide enough for t + 1
	typedef logic [$clog2(BCH_T+2)-1:0] bch_cnt_t;

endpackage

/* design/chien_search.sv */
`timescale 1ns/1ps

module chien_search (
	input  logic   i_clk,
	input  logic   i_rst,
	locator_if.dst i_lam,
	roots_if.src   o_roots
);
	import gf_pkg::*;
	import bch_pkg::*;

	logic     busy;                 // search running
	logic     load;
	logic     hit;
	bch_pos_t step;                 // position under test
	gf_elem_t lam0_q;
	gf_elem_t term1;                // lam1 * alpha^-step
	gf_elem_t term2;                // lam2 * alpha^-2*step

	assign load          = i_lam.valid & i_lam.ready;
	assign i_lam.ready   = ~(busy | o_roots.valid);
	assign hit           = ((lam0_q ^ term1 ^ term2) == '0);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			busy          <= 1'b0;
			step          <= '0;
			o_roots.valid <= 1'b0;
		end else if (load) begin
			busy <= 1'b1;
			step <= '0;
		end else if (busy) begin
			if (step == bch_pos_t'(BCH_N - 1)) begin
				busy          <= 1'b0;
				o_roots.valid <= 1'b1;
			end else begin
				step <= step + 1'b1;
			end
		end else if (o_roots.valid && o_roots.ready) begin
			o_roots.valid <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (load) begin
			lam0_q         <= i_lam.lam0;
			term1          <= i_lam.lam1;
			term2          <= i_lam.lam2;
			o_roots.degree <= i_lam.degree;
			o_roots.count  <= '0;
		end else if (busy) begin
			term1 <= gf_mul(term1, gf_alpha_pow(BCH_N - 1));
			term2 <= gf_mul(term2, gf_alpha_pow(BCH_N - 2));
			if (hit && o_roots.count != bch_cnt_t'(BCH_T + 1)) begin
				o_roots.count <= o_roots.count + 1'b1;    // saturates at t+1
				if (o_roots.count == '0)
					o_roots.loc0 <= step;
				else if (o_roots.count == bch_cnt_t'(1))
					o_roots.loc1 <= step;
			end
		end
	end

	a_step_range: assert property (@(posedge i_clk) disable iff (i_rst)
		busy |-> step <= bch_pos_t'(BCH_N - 1));

endmodule

/* design/error_report.sv */
`timescale 1ns/1ps

module error_report (
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic              i_loc_ready,
	roots_if.dst              i_roots,
	output bch_pkg::bch_pos_t o_loc,
	output logic              o_loc_valid,
	output logic              o_done,
	output bch_pkg::bch_cnt_t o_num_err,
	output logic              o_fail
);
	import bch_pkg::*;

	bch_pos_t loc0_q;
	bch_pos_t loc1_q;
	bch_cnt_t cnt_q;
	logic     fail_q;
	logic     idx;              // which location is on o_loc
	logic     load;
	logic     fail_in;

	assign load          = i_roots.valid & i_roots.ready;
	assign i_roots.ready = ~(o_loc_valid | o_done);
	// roots must match the locator degree
	assign fail_in   = (i_roots.count != i_roots.degree) || (i_roots.count > bch_cnt_t'(BCH_T));
	assign o_loc     = idx ? loc1_q : loc0_q;
	assign o_num_err = fail_q ? '0 : cnt_q;
	assign o_fail    = fail_q;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_loc_valid <= 1'b0;
			o_done      <= 1'b0;
			idx         <= 1'b0;
			fail_q      <= 1'b0;
			cnt_q       <= '0;
		end else begin
			o_done <= 1'b0;
			if (load) begin
				idx    <= 1'b0;
				fail_q <= fail_in;
				cnt_q  <= i_roots.count;
				if (fail_in || i_roots.count == '0)
					o_done <= 1'b1;                 // nothing to stream
				else
					o_loc_valid <= 1'b1;
			end else if (o_loc_valid && i_loc_ready) begin
				if (idx || cnt_q == bch_cnt_t'(1)) begin
					o_loc_valid <= 1'b0;
					o_done      <= 1'b1;
				end else begin
					idx <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (load) begin
			loc0_q <= i_roots.loc0;
			loc1_q <= i_roots.loc1;
		end
	end

	a_done_alone: assert property (@(posedge i_clk) disable iff (i_rst)
		!(o_loc_valid && o_done));

endmodule

/* design/gf_pkg.sv */
package gf_pkg;

	// ==================================================
	// GF(2^6) with primitive polynomial x^6 + x + 1
	// ==================================================
	localparam int GF_M = 6;
	localparam logic [GF_M-1:0] GF_POLY = 6'b000011;    // x^6 folds back to x + 1

	typedef logic [GF_M-1:0] gf_elem_t;

	// shift-and-add multiply, reduced on every shift
	function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
		gf_elem_t acc;
		gf_elem_t sh;
		acc = '0;
		sh  = a;
		for (int i = 0; i < GF_M; i++) begin
			if (b[i])
				acc ^= sh;
			sh = sh[GF_M-1] ? ({sh[GF_M-2:0], 1'b0} ^ GF_POLY) : {sh[GF_M-2:0], 1'b0};
		end
		return acc;
	endfunction

	function automatic gf_elem_t gf_sq(input gf_elem_t a);
		return gf_mul(a, a);
	endfunction

	function automatic gf_elem_t gf_alpha_pow(input int unsigned e);
		gf_elem_t    r;
		int unsigned n;
		r = gf_elem_t'(1);
		n = e % ((1 << GF_M) - 1);          // alpha^63 = 1
		for (int i = 0; i < (1 << GF_M) - 1; i++) begin
			if (i < n)
				r = gf_mul(r, gf_elem_t'(2));    // alpha is x, i.e. 2
		end
		return r;
	endfunction

endpackage

/* design/ibm_solver.sv */
`timescale 1ns/1ps

module ibm_solver (
	input  logic    i_clk,
	input  logic    i_rst,
	syndrome_if.dst i_syn,
	locator_if.src  o_loc
);
	import gf_pkg::*;

	logic       iter_pend;              // second iteration still to run
	logic       load;
	gf_elem_t   s1_q;
	gf_elem_t   s3_q;
	gf_elem_t   b1_q;                   // x^1 term of correction poly
	gf_elem_t   gam_q;
	logic [1:0] len_q;
	gf_elem_t   op_l0, op_l1, op_l2;
	gf_elem_t   op_b0, op_b1, op_gam, op_sa;
	logic [1:0] op_len;
	gf_elem_t   delta;
	logic       swap;
	gf_elem_t   nx_l0, nx_l1, nx_l2, nx_b1, nx_gam;
	logic [1:0] nx_len;

	assign load        = i_syn.valid & i_syn.ready;
	assign i_syn.ready = ~(iter_pend | o_loc.valid);

	// ==================================================
	// one iBM step, shared by both iterations
	// ==================================================
	always_comb begin
		op_l0  = load ? gf_elem_t'(1) : o_loc.lam0;
		op_l1  = load ? '0 : o_loc.lam1;
		op_l2  = load ? '0 : o_loc.lam2;
		op_b0  = gf_elem_t'(load);          // no constant term once stepped
		op_b1  = load ? '0 : b1_q;
		op_gam = load ? gf_elem_t'(1) : gam_q;
		op_len = load ? 2'd0 : len_q;
		op_sa  = load ? i_syn.s1 : s3_q;
		delta  = gf_mul(op_l0, op_sa) ^ gf_mul(op_l1, gf_sq(s1_q)) ^ gf_mul(op_l2, s1_q);
		swap   = (delta != '0) && (op_len <= (load ? 2'd0 : 2'd1));
		nx_l0  = gf_mul(op_gam, op_l0);
		nx_l1  = gf_mul(op_gam, op_l1) ^ gf_mul(delta, op_b0);
		nx_l2  = gf_mul(op_gam, op_l2) ^ gf_mul(delta, op_b1);
		nx_b1  = swap ? op_l0 : '0;         // x*lam or x^2*B
		nx_gam = swap ? delta : op_gam;
		nx_len = swap ? ((load ? 2'd1 : 2'd3) - op_len) : op_len;
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			iter_pend   <= 1'b0;
			o_loc.valid <= 1'b0;
		end else if (load) begin
			iter_pend <= 1'b1;
		end else if (iter_pend) begin
			iter_pend   <= 1'b0;
			o_loc.valid <= 1'b1;
		end else if (o_loc.valid && o_loc.ready) begin
			o_loc.valid <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (load) begin
			s1_q <= i_syn.s1;
			s3_q <= i_syn.s3;
		end
		if (load || iter_pend) begin
			o_loc.lam0 <= nx_l0;
			o_loc.lam1 <= nx_l1;
			o_loc.lam2 <= nx_l2;
			b1_q       <= nx_b1;
			gam_q      <= nx_gam;
			len_q      <= nx_len;
		end
	end

	assign o_loc.degree = len_q;

	a_loc_stable: assert property (@(posedge i_clk) disable iff (i_rst)
		o_loc.valid && !o_loc.ready |=> o_loc.valid && $stable(o_loc.lam0)
			&& $stable(o_loc.lam1) && $stable(o_loc.lam2) && $stable(o_loc.degree));

endmodule

/* design/syndrome_calc.sv */
`timescale 1ns/1ps

module syndrome_calc (
	input  logic    i_clk,
	input  logic    i_rst,
	input  logic    i_bit,
	input  logic    i_valid,
	output logic    o_ready,
	syndrome_if.src o_syn
);
	import gf_pkg::*;
	import bch_pkg::*;

	bch_pos_t bit_cnt;          // bits taken in this frame
	gf_elem_t acc1;
	gf_elem_t acc3;
	gf_elem_t acc1_nxt;
	gf_elem_t acc3_nxt;
	logic     take;
	logic     last;

	assign o_ready = ~o_syn.valid;          // hold input while result waits
	assign take    = i_valid & o_ready;
	assign last    = (bit_cnt == bch_pos_t'(BCH_N - 1));

	// horner steps for r(alpha) and r(alpha^3), first bit is x^62
	always_comb begin
		acc1_nxt    = (bit_cnt == '0) ? '0 : gf_mul(acc1, gf_alpha_pow(1));
		acc3_nxt    = (bit_cnt == '0) ? '0 : gf_mul(acc3, gf_alpha_pow(3));
		acc1_nxt[0] = acc1_nxt[0] ^ i_bit;
		acc3_nxt[0] = acc3_nxt[0] ^ i_bit;
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			bit_cnt     <= '0;
			o_syn.valid <= 1'b0;
		end else begin
			if (o_syn.valid && o_syn.ready)
				o_syn.valid <= 1'b0;
			if (take) begin
				if (last) begin
					bit_cnt     <= '0;
					o_syn.valid <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (take) begin
			acc1 <= acc1_nxt;
			acc3 <= acc3_nxt;
			if (last) begin
				o_syn.s1 <= acc1_nxt;   // final sums
				o_syn.s3 <= acc3_nxt;
			end
		end
	end

	a_no_take_while_held: assert property (@(posedge i_clk) disable iff (i_rst)
		o_syn.valid |=> bit_cnt == '0 && $stable(o_syn.s1) && $stable(o_syn.s3));

endmodule

/* include/bch_ref.svh */
`ifndef BCH_REF_SVH
`define BCH_REF_SVH

// systematic encoder, g(x) = m1(x) * m3(x) = x^12+x^10+x^8+x^5+x^4+x^3+1
function automatic logic [bch_pkg::BCH_N-1:0] bch_encode(
	input logic [bch_pkg::BCH_K-1:0] msg
);
	logic [bch_pkg::BCH_N-bch_pkg::BCH_K-1:0] rem;
	logic                                     fb;
	rem = '0;
	for (int i = bch_pkg::BCH_K - 1; i >= 0; i--) begin
		fb  = msg[i] ^ rem[bch_pkg::BCH_N-bch_pkg::BCH_K-1];
		rem = {rem[bch_pkg::BCH_N-bch_pkg::BCH_K-2:0], 1'b0};
		if (fb)
			rem ^= 12'h539;         // g(x) without x^12
	end
	return {msg, rem};
endfunction

// brute force over single positions and then pairs
function automatic void bch_ref_decode(
	input  logic [bch_pkg::BCH_N-1:0] rx,
	output bch_pkg::bch_pos_t         loc0,
	output bch_pkg::bch_pos_t         loc1,
	output bch_pkg::bch_cnt_t         cnt,
	output logic                      fail
);
	gf_pkg::gf_elem_t pw [bch_pkg::BCH_N];
	gf_pkg::gf_elem_t s1;
	gf_pkg::gf_elem_t s3;
	s1   = '0;
	s3   = '0;
	loc0 = '0;
	loc1 = '0;
	cnt  = '0;
	fail = 1'b0;
	for (int p = 0; p < bch_pkg::BCH_N; p++)
		pw[p] = gf_pkg::gf_alpha_pow(p);
	for (int p = 0; p < bch_pkg::BCH_N; p++) begin
		if (rx[p]) begin
			s1 ^= pw[p];
			s3 ^= pw[(3 * p) % bch_pkg::BCH_N];
		end
	end
	if (s1 == '0 && s3 == '0)
		return;
	for (int p = 0; p < bch_pkg::BCH_N; p++) begin
		if (pw[p] == s1 && pw[(3 * p) % bch_pkg::BCH_N] == s3) begin
			loc0 = bch_pkg::bch_pos_t'(p);
			cnt  = bch_pkg::bch_cnt_t'(1);
			return;
		end
	end
	for (int p = 0; p < bch_pkg::BCH_N; p++) begin
		for (int q = p + 1; q < bch_pkg::BCH_N; q++) begin
			if ((pw[p] ^ pw[q]) == s1 &&
			    (pw[(3 * p) % bch_pkg::BCH_N] ^ pw[(3 * q) % bch_pkg::BCH_N]) == s3) begin
				loc0 = bch_pkg::bch_pos_t'(p);
				loc1 = bch_pkg::bch_pos_t'(q);
				cnt  = bch_pkg::bch_cnt_t'(2);
				return;
			end
		end
	end
	fail = 1'b1;                    // three or more errors
endfunction

`endif

/* testbench/tb_bch_decoder.sv */
`timescale 1ns/1ps

module tb_bch_decoder;
	import bch_pkg::*;

	`include "bch_ref.svh"

	localparam int CLK_PERIOD = 100;
	localparam int N_DOUBLE   = 8;
	localparam int N_MULTI    = 12;
	localparam int N_STREAM   = 16;
	localparam int NUM_FRAMES = 1 + 3 + N_DOUBLE + N_MULTI + N_STREAM;

	typedef struct packed {
		bch_pos_t loc0;
		bch_pos_t loc1;
		bch_cnt_t cnt;
		logic     fail;
	} exp_t;

	logic     i_clk;
	logic     i_rst;
	logic     i_bit;
	logic     i_valid;
	logic     o_ready;
	bch_pos_t o_loc;
	logic     o_loc_valid;
	logic     i_loc_ready;
	logic     o_done;
	bch_cnt_t o_num_err;
	logic     o_fail;

	exp_t exp_q [$];                    // one entry per frame sent
	int   n_checks    = 0;
	int   n_errors    = 0;
	int   frames_sent = 0;
	int   frames_done = 0;
	int   test_num    = 0;
	int   err_base    = 0;
	int   chk_base    = 0;
	logic stall_en;

	bch_decoder u_bch_decoder (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_bit       (i_bit),
		.i_valid     (i_valid),
		.o_ready     (o_ready),
		.o_loc       (o_loc),
		.o_loc_valid (o_loc_valid),
		.i_loc_ready (i_loc_ready),
		.o_done      (o_done),
		.o_num_err   (o_num_err),
		.o_fail      (o_fail)
	);

	initial begin : clock_proc
		i_clk = 1'b0;
		forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
	end

	// ==================================================
	// compare tasks
	// ==================================================
	task automatic check_loc(input string name, input bch_pos_t got, input bch_pos_t want);
		n_checks++;
		if (got !== want) begin
			$display("** Error: %s got 0x%0h, expected 0x%0h", name, got, want);
			n_errors++;
		end
	endtask

	task automatic check_count(input string name, input bch_cnt_t got, input bch_cnt_t want);
		n_checks++;
		if (got !== want) begin
			$display("** Error: %s got 0x%0h, expected 0x%0h", name, got, want);
			n_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		n_checks++;
		if (got !== want) begin
			$display("** Error: %s got 0x%0h, expected 0x%0h", name, got, want);
			n_errors++;
		end
	endtask

	// ==================================================
	// stimulus helpers
	// ==================================================
	function automatic logic [BCH_N-1:0] random_codeword();
		logic [63:0] r;
		r = {$urandom, $urandom};
		return bch_encode(r[BCH_K-1:0]);
	endfunction

	function automatic logic [BCH_N-1:0] random_flips(input int unsigned n);
		logic [BCH_N-1:0] e;
		e = '0;
		while ($countones(e) < n)
			e[$urandom_range(0, BCH_N - 1)] = 1'b1;
		return e;
	endfunction

	// up to t flips are found as they are, beyond that the brute force decoder decides
	function automatic exp_t expect_for(input logic [BCH_N-1:0] rx, input logic [BCH_N-1:0] e);
		exp_t     w;
		bch_pos_t l0;
		bch_pos_t l1;
		bch_cnt_t c;
		logic     f;
		w = '0;
		if ($countones(e) <= BCH_T) begin
			for (int p = 0; p < BCH_N; p++) begin
				if (e[p]) begin
					if (w.cnt == '0)
						w.loc0 = bch_pos_t'(p);
					else
						w.loc1 = bch_pos_t'(p);
					w.cnt = w.cnt + 1'b1;
				end
			end
		end else begin
			bch_ref_decode(rx, l0, l1, c, f);
			w.loc0 = l0;
			w.loc1 = l1;
			w.cnt  = c;
			w.fail = f;
		end
		return w;
	endfunction

	// called at a falling edge, returns at one
	task automatic send_frame(input logic [BCH_N-1:0] rx, input bit gaps);
		logic taken;
		for (int i = BCH_N - 1; i >= 0; i--) begin
			if (gaps && $urandom_range(0, 3) == 0) begin
				i_valid = 1'b0;
				repeat ($urandom_range(1, 3)) @(negedge i_clk);
			end
			i_bit   = rx[i];                // x^62 goes first
			i_valid = 1'b1;
			do begin
				taken = o_ready;            // decides the coming rising edge
				@(negedge i_clk);
			end while (!taken);
		end
		i_valid = 1'b0;
	endtask

	task automatic run_frame(input logic [BCH_N-1:0] e, input bit gaps);
		logic [BCH_N-1:0] rx;
		rx = random_codeword() ^ e;
		exp_q.push_back(expect_for(rx, e));
		frames_sent++;
		send_frame(rx, gaps);
	endtask

	task automatic end_test(input string name);
		wait (frames_done == frames_sent);
		test_num++;
		$display("test %0d %s: %s, checks %0d, errors %0d", test_num, name,
			(n_errors == err_base) ? "ok" : "FAILED", n_checks - chk_base, n_errors - err_base);
		err_base = n_errors;
		chk_base = n_checks;
		@(negedge i_clk);                   // back on the drive edge
	endtask

	// ==================================================
	// result collection
	// ==================================================
	initial begin : compare_proc
		bch_pos_t got_loc [$];
		exp_t     want;
		forever begin
			@(posedge i_clk);
			if (!i_rst) begin
				if (o_loc_valid && i_loc_ready)
					got_loc.push_back(o_loc);
				if (o_done) begin
					if (exp_q.size() == 0) begin
						$display("o_done pulsed with no frame outstanding");
						n_errors++;
					end else begin
						want = exp_q.pop_front();
						check_count("o_num_err", o_num_err, want.cnt);
						check_flag("o_fail", o_fail, want.fail);
						if (got_loc.size() != int'(want.cnt)) begin
							$display("frame %0d streamed %0d locations instead of %0d",
								frames_done, got_loc.size(), want.cnt);
							n_errors++;
						end else begin
							if (got_loc.size() > 0)
								check_loc("o_loc", got_loc[0], want.loc0);
							if (got_loc.size() > 1)
								check_loc("o_loc", got_loc[1], want.loc1);
						end
					end
					got_loc.delete();
					frames_done++;
				end
			end
		end
	end

	initial begin : ready_proc
		int unsigned hold;
		forever begin
			@(negedge i_clk);
			if (stall_en && $urandom_range(0, 7) == 0) begin
				i_loc_ready = 1'b0;         // low stretch
				hold = $urandom_range(1, 20);
				repeat (hold) @(negedge i_clk);
			end
			i_loc_ready = 1'b1;
		end
	end

	initial begin : watchdog_proc
		#(NUM_FRAMES * 200 * CLK_PERIOD * 2);
		$display("timeout, the decoder stopped delivering frame results");
		$display("Errors found");
		$finish;
	end

	// ==================================================
	// test sequence
	// ==================================================
	initial begin : main_proc
		int unsigned seed;
		seed        = $urandom(13587);
		i_rst       = 1'b1;
		i_bit       = 1'b0;
		i_valid     = 1'b0;
		i_loc_ready = 1'b1;
		stall_en    = 1'b0;
		repeat (8) @(posedge i_clk);
		@(negedge i_clk);
		i_rst = 1'b0;
		@(negedge i_clk);

		check_flag("o_ready", o_ready, 1'b1);
		check_flag("o_loc_valid", o_loc_valid, 1'b0);
		check_flag("o_done", o_done, 1'b0);
		end_test("reset state");

		run_frame('0, 1'b0);
		end_test("clean codeword");

		for (int k = 0; k < 3; k++)
			run_frame(BCH_N'(1) << (31 * k), 1'b0);    // 0, 31, 62
		end_test("single errors");

		repeat (N_DOUBLE) run_frame(random_flips(2), 1'b0);
		end_test("double errors");

		repeat (N_MULTI) run_frame(random_flips($urandom_range(3, 5)), 1'b0);
		end_test("three to five flips");

		stall_en = 1'b1;
		repeat (N_STREAM) run_frame(random_flips($urandom_range(0, 5)), 1'b1);
		end_test("back to back with stalls");
		stall_en = 1'b0;

		$display("tests %0d, frames %0d, checks %0d, errors %0d",
			test_num, frames_done, n_checks, n_errors);
		if (n_errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule
